//--- Bender.yml
package:
  name: cpu_system

sources:
  - cpuPkg.sv
  - regFile.sv
  - insnDecode.sv
  - execUnit.sv
  - cpuCore.sv
  - unifiedMem.sv
  - cpuSystem.sv
  - target: test
    files:
      - cpuCore_properties.sv
      - cpuChecker.sv
      - cpuTb.sv

//--- cpuChecker.sv
`default_nettype none

module cpuChecker #(
    parameter int ADDR_BITS = 10
) (
    input  wire        clk,
    input  wire        reset_n,
    input  wire        halt,
    input  wire        running,
    input  wire        loadEn,
    input  wire [31:0] loadAddr,
    input  wire [31:0] loadData,
    input  wire        storeValid,
    input  wire [31:0] storeAddr,
    input  wire [31:0] storeData,
    output logic       done,
    output int         errorCount,
    output int         checkedCount,
    output int         pendingCount
);

    localparam int MAX_STEPS = 2000;

    logic [31:0] modelMem [0:(2**ADDR_BITS)-1];  // Image as seen on the load port
    logic [31:0] modelRegs [1:14];
    logic [31:0] expAddr [$];
    logic [31:0] expData [$];
    logic        modelBuilt;
    logic        haltSeenLow;

    initial begin
        done         = 1'b0;
        errorCount   = 0;
        checkedCount = 0;
        pendingCount = 0;
        modelBuilt   = 1'b0;
        haltSeenLow  = 1'b0;
    end

    // Operation table with A and B signed and all-ones for a true comparison
    function automatic logic [31:0] aluModel(input logic [3:0] op, input logic [31:0] a,
                                             input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            cpuPkg::opOr:   return a | b;
            cpuPkg::opAnd:  return a & b;
            cpuPkg::opAdd:  return a + b;
            cpuPkg::opMul:  return a * b;
            cpuPkg::opShl:  return a << sh;
            cpuPkg::opLt:   return {32{$signed(a) < $signed(b)}};
            cpuPkg::opEq:   return {32{a == b}};
            cpuPkg::opGe:   return {32{$signed(a) >= $signed(b)}};
            cpuPkg::opAndn: return a & ~b;
            cpuPkg::opXor:  return a ^ b;
            cpuPkg::opSub:  return a - b;
            cpuPkg::opXnor: return ~(a ^ b);
            cpuPkg::opShr:  return a >> sh;
            cpuPkg::opNe:   return {32{a != b}};
            cpuPkg::opSra:  return $signed(a) >>> sh;
            default:        return '0;
        endcase
    endfunction

    function automatic logic [31:0] readReg(input logic [3:0] idx, input logic [31:0] p);
        if (idx == 4'd0) return '0;
        if (idx == 4'd15) return p;    // P is the address after the current instruction
        return modelRegs[idx];
    endfunction

    task automatic expectStore(input logic [31:0] addr, input logic [31:0] data);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    // Instruction-set model run once on the loaded image
    task automatic runModel();
        logic [31:0] pc, insn, p, imm, a, b, c, res, val, zv, tableAddr;
        logic [3:0]  z;
        logic        stop;
        int          steps;
        pc    = cpuPkg::RESET_VECTOR;
        stop  = 1'b0;
        steps = 0;
        while (!stop && steps < MAX_STEPS) begin
            insn = modelMem[pc[ADDR_BITS-1:0]];
            p    = pc + 32'd1;
            z    = insn[27:24];
            imm  = {{20{insn[11]}}, insn[11:0]};
            steps++;
            if (insn[31:30] == cpuPkg::kindThrow) begin
                // Return address goes to the trap word before the jump to the handler
                tableAddr = cpuPkg::VECTOR_BASE | {27'd0, insn[4:0]};
                expectStore(cpuPkg::TRAP_ADDR, p);
                modelMem[cpuPkg::TRAP_ADDR] = p;
                pc = modelMem[tableAddr[ADDR_BITS-1:0]];
            end else begin
                case (insn[31:30])
                    cpuPkg::kindXYI: begin
                        a = readReg(insn[23:20], p);
                        b = readReg(insn[19:16], p);
                        c = imm;
                    end
                    cpuPkg::kindXIY: begin
                        a = readReg(insn[23:20], p);
                        b = imm;
                        c = readReg(insn[19:16], p);
                    end
                    default: begin
                        a = imm;
                        b = readReg(insn[23:20], p);
                        c = readReg(insn[19:16], p);
                    end
                endcase
                res = aluModel(insn[15:12], a, b) + c;
                zv  = readReg(z, p);
                if (insn[29]) begin
                    if (insn[28]) begin
                        expectStore(res, zv);            // Z to the computed address
                        modelMem[res[ADDR_BITS-1:0]] = zv;
                    end else begin
                        expectStore(zv, res);            // Result to the address in Z
                        modelMem[zv[ADDR_BITS-1:0]] = res;
                    end
                    pc = p;
                end else begin
                    val = insn[28] ? modelMem[res[ADDR_BITS-1:0]] : res;
                    if (z == 4'd15) begin
                        stop = (val == pc);   // Final spin loop
                        pc   = val;
                    end else begin
                        if (z != 4'd0) modelRegs[z] = val;
                        pc = p;
                    end
                end
            end
        end
        if (!stop) begin
            errorCount++;
            $display("Model did not reach the final loop within %0d instructions", MAX_STEPS);
        end
    endtask

    task automatic compareStore();
        logic [31:0] a, d;
        if (expAddr.size() == 0) begin
            errorCount++;
            $display("Unexpected extra store of %h to %h at time %0t", storeData, storeAddr,
                     $time);
        end else begin
            a = expAddr.pop_front();
            d = expData.pop_front();
            if (storeAddr !== a || storeData !== d) begin
                errorCount++;
                $display("mismatch at time %0t: store %0d expected [%h] <= %h, got [%h] <= %h",
                         $time, checkedCount, a, d, storeAddr, storeData);
            end
            checkedCount++;
        end
    endtask

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        if (reset_n) begin
            if (loadEn) begin
                modelMem[loadAddr[ADDR_BITS-1:0]] = loadData;
            end
            if (!halt && !modelBuilt) begin
                runModel();
                modelBuilt = 1'b1;
            end
            if (halt && running) begin
                errorCount++;
                $display("Core running while halt is high at time %0t", $time);
            end
            // One edge after halt drops the core has left sIdle for good
            if (!halt && haltSeenLow && running !== 1'b1) begin
                errorCount++;
                $display("Core not running after halt dropped at time %0t", $time);
            end
            haltSeenLow = !halt;
            if (halt && storeValid) begin
                errorCount++;
                $display("Store to %h seen while halt is high at time %0t", storeAddr, $time);
            end else if (storeValid) begin
                compareStore();
            end
            pendingCount = expAddr.size();
            done         = modelBuilt && (pendingCount == 0);
        end
    end

endmodule

`default_nettype wire

//--- cpuCore.sv
`default_nettype none

module cpuCore (
    input  wire                           clk,
    input  wire                           reset_n,
    input  wire                           halt,
    output logic [cpuPkg::DATA_WIDTH-1:0] iAddr,
    input  wire  [cpuPkg::DATA_WIDTH-1:0] iData,
    output logic [cpuPkg::DATA_WIDTH-1:0] dAddr,
    output logic [cpuPkg::DATA_WIDTH-1:0] dOut,
    input  wire  [cpuPkg::DATA_WIDTH-1:0] dIn,
    output logic                          memStrobe,
    output logic                          memWrite,
    output logic                          running
);

    cpuPkg::coreState state, stateNext;

    logic [cpuPkg::DATA_WIDTH-1:0] insn;
    logic [cpuPkg::DATA_WIDTH-1:0] resultReg;
    logic [cpuPkg::DATA_WIDTH-1:0] loadedData;
    logic [cpuPkg::DATA_WIDTH-1:0] nextP;
    logic [cpuPkg::DATA_WIDTH-1:0] vecTarget;

    logic [3:0]                    idxZ, idxX, idxY;
    logic [cpuPkg::DATA_WIDTH-1:0] imm;
    cpuPkg::aluOp                  op;
    cpuPkg::opKind                 kind;
    logic                          storing, derefRhs, throwing, jumping;
    logic [4:0]                    vector;
    logic [cpuPkg::DATA_WIDTH-1:0] valZ, valX, valY;
    logic [cpuPkg::DATA_WIDTH-1:0] aluResult;
    logic [cpuPkg::DATA_WIDTH-1:0] nextZ;
    logic                          loading;
    logic                          regWrite;

    always_comb begin
        case (state)
            cpuPkg::sIdle:    stateNext = halt ? cpuPkg::sIdle : cpuPkg::sNextP;
            cpuPkg::sIssue: begin
                if (halt) begin
                    stateNext = cpuPkg::sIdle;
                end else if (throwing) begin
                    stateNext = cpuPkg::sThrow;
                end else begin
                    stateNext = cpuPkg::sArrange;
                end
            end
            cpuPkg::sArrange: stateNext = cpuPkg::sExecute;
            cpuPkg::sExecute: stateNext = cpuPkg::sSettle;
            cpuPkg::sSettle:  stateNext = cpuPkg::sMemory;   // Slack for the multiplier
            cpuPkg::sMemory:  stateNext = cpuPkg::sCommit;
            cpuPkg::sCommit:  stateNext = cpuPkg::sNextP;
            cpuPkg::sNextP:   stateNext = cpuPkg::sFetch;
            cpuPkg::sFetch:   stateNext = cpuPkg::sIssue;
            cpuPkg::sThrow:   stateNext = cpuPkg::sVector;
            cpuPkg::sVector:  stateNext = cpuPkg::sSaveRet;
            cpuPkg::sSaveRet: stateNext = cpuPkg::sJump;
            cpuPkg::sJump:    stateNext = cpuPkg::sNextP;
            default:          stateNext = cpuPkg::sIdle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= cpuPkg::sIdle;
        end else begin
            state <= stateNext;
        end
    end

    // Datapath registers, one owner state each
    always_ff @(posedge clk) begin
        case (state)
            cpuPkg::sIdle:    iAddr <= cpuPkg::RESET_VECTOR;
            cpuPkg::sExecute: resultReg <= aluResult;
            cpuPkg::sMemory:  loadedData <= dIn;
            cpuPkg::sCommit:  iAddr <= jumping ? nextZ : nextP;
            cpuPkg::sNextP:   nextP <= iAddr + 32'd1;
            cpuPkg::sFetch:   insn <= iData;
            cpuPkg::sThrow:   resultReg <= cpuPkg::VECTOR_BASE | vector;
            cpuPkg::sVector:  vecTarget <= dIn;      // Handler address from the table
            cpuPkg::sSaveRet: resultReg <= nextP;    // Resume after the throw
            cpuPkg::sJump:    iAddr <= vecTarget;
            default: ;
        endcase
    end

    insnDecode decode0 (
        .insn     (insn),
        .idxZ     (idxZ),
        .idxX     (idxX),
        .idxY     (idxY),
        .imm      (imm),
        .op       (op),
        .kind     (kind),
        .storing  (storing),
        .derefRhs (derefRhs),
        .throwing (throwing),
        .jumping  (jumping),
        .vector   (vector)
    );

    execUnit exec0 (
        .clk       (clk),
        .arrangeEn (state == cpuPkg::sIssue),
        .executeEn (state == cpuPkg::sArrange),
        .kind      (kind),
        .op        (op),
        .valX      (valX),
        .valY      (valY),
        .imm       (imm),
        .result    (aluResult)
    );

    // Memory access in sMemory, trap word store in sJump
    assign loading   = derefRhs && !storing;
    assign memStrobe = (state == cpuPkg::sMemory && (storing || derefRhs))
                       || state == cpuPkg::sJump;
    assign memWrite  = memStrobe && (storing || state == cpuPkg::sJump);

    always_comb begin
        if (state == cpuPkg::sJump) begin
            dAddr = cpuPkg::TRAP_ADDR;
        end else if (derefRhs || state == cpuPkg::sVector) begin
            dAddr = resultReg;
        end else begin
            dAddr = valZ;    // Plain store goes to the address in Z
        end
    end

    assign dOut = (derefRhs && state != cpuPkg::sJump) ? valZ : resultReg;

    // Write back, suppressed for stores
    assign nextZ    = loading ? loadedData : resultReg;
    assign regWrite = (state == cpuPkg::sCommit) && !storing;

    regFile regs0 (
        .clk     (clk),
        .writeEn (regWrite),
        .idxZ    (idxZ),
        .idxX    (idxX),
        .idxY    (idxY),
        .nextZ   (nextZ),
        .nextP   (nextP),
        .valZ    (valZ),
        .valX    (valX),
        .valY    (valY)
    );

    assign running = (state != cpuPkg::sIdle);

endmodule

`default_nettype wire

//--- cpuCore_properties.sv
`default_nettype none

module cpuCoreProperties (
    input wire                   clk,
    input wire                   reset_n,
    input wire                   halt,
    input wire cpuPkg::coreState state,
    input wire                   memStrobe,
    input wire                   memWrite
);

    int failCount = 0;

    // Data port is used only for the access and trap word states
    strobeInAccessState: assert property (
        @(posedge clk) disable iff (!reset_n)
        memStrobe |-> (state == cpuPkg::sMemory || state == cpuPkg::sJump)
    ) else begin
        $error("Memory strobe high outside sMemory and sJump");
        failCount++;
    end

    writeNeedsStrobe: assert property (
        @(posedge clk) disable iff (!reset_n)
        memWrite |-> memStrobe
    ) else begin
        $error("Memory write without memory strobe");
        failCount++;
    end

    // Normal instruction is 8 cycles, a throw is 7
    issueReturns: assert property (
        @(posedge clk) disable iff (!reset_n || halt)
        (state == cpuPkg::sIssue) |=> ##[0:7] (state == cpuPkg::sIssue)
    ) else begin
        $error("Core did not return to sIssue within 8 cycles");
        failCount++;
    end

endmodule

`default_nettype wire

//--- cpuPkg.sv
`default_nettype none

package cpuPkg;

    localparam int DATA_WIDTH = 32;

    // Fixed addresses of the memory map
    localparam logic [DATA_WIDTH-1:0] RESET_VECTOR = 32'h100;  // First fetched instruction
    localparam logic [DATA_WIDTH-1:0] VECTOR_BASE  = 32'h20;   // Throw table, or'ed with vector
    localparam logic [DATA_WIDTH-1:0] TRAP_ADDR    = 32'h1f;   // Receives the return address

    // ALU operations, in encoding order
    typedef enum logic [3:0] {
        opOr, opAnd, opAdd, opMul,
        opReserved, opShl, opLt, opEq,
        opGe, opAndn, opXor, opSub,
        opXnor, opShr, opNe, opSra
    } aluOp;

    // Operand arrangement into A, B and C
    typedef enum logic [1:0] {
        kindXYI,    // A = X, B = Y, C = imm
        kindXIY,    // A = X, B = imm, C = Y
        kindIXY,    // A = imm, B = X, C = Y
        kindThrow
    } opKind;

    typedef enum logic [3:0] {
        sIdle,
        sIssue, sArrange, sExecute, sSettle,
        sMemory, sCommit, sNextP, sFetch,
        sThrow,     // Table address formed
        sVector,    // Handler address read
        sSaveRet,
        sJump       // Return address stored at the trap word
    } coreState;

endpackage

`default_nettype wire

//--- cpuSystem.sv
`default_nettype none

module cpuSystem #(
    parameter int ADDR_BITS = 10
) (
    input  wire                           clk,
    input  wire                           reset_n,
    input  wire                           halt,
    input  wire                           loadEn,
    input  wire  [cpuPkg::DATA_WIDTH-1:0] loadAddr,
    input  wire  [cpuPkg::DATA_WIDTH-1:0] loadData,
    output logic                          running,
    output logic                          storeValid,
    output logic [cpuPkg::DATA_WIDTH-1:0] storeAddr,
    output logic [cpuPkg::DATA_WIDTH-1:0] storeData
);

    logic [cpuPkg::DATA_WIDTH-1:0] iAddr, iData;
    logic [cpuPkg::DATA_WIDTH-1:0] dAddr, dOut, dIn;
    logic                          memStrobe, memWrite;

    cpuCore core0 (
        .clk       (clk),
        .reset_n   (reset_n),
        .halt      (halt),
        .iAddr     (iAddr),
        .iData     (iData),
        .dAddr     (dAddr),
        .dOut      (dOut),
        .dIn       (dIn),
        .memStrobe (memStrobe),
        .memWrite  (memWrite),
        .running   (running)
    );

    unifiedMem #(
        .ADDR_BITS (ADDR_BITS)
    ) mem0 (
        .clk      (clk),
        .iAddr    (iAddr),
        .iData    (iData),
        .dAddr    (dAddr),
        .dWrData  (dOut),
        .dRdData  (dIn),
        .dStrobe  (memStrobe),
        .dWrite   (memWrite),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData)
    );

    // Store monitor
    assign storeValid = memStrobe && memWrite;
    assign storeAddr  = dAddr;
    assign storeData  = dOut;

endmodule

`default_nettype wire

//--- cpuTb.sv
`default_nettype none

module cpuTb;

    localparam int ADDR_BITS       = 10;
    localparam int BODY_LEN        = 64;
    localparam int EXEC_BOUND      = 2 * 14 + BODY_LEN + 2 * 2 + 4;  // Init and dump, handlers
    localparam int WATCHDOG_CYCLES = EXEC_BOUND * 8 + 200;

    localparam logic [31:0] HANDLER_ADDR = 32'h1c0;
    localparam logic [31:0] HANDLER_SAVE = 32'h2f0;
    localparam logic [31:0] DUMP_BASE    = 32'h300;

    logic        clk, reset_n, halt, loadEn;
    logic [31:0] loadAddr, loadData;
    logic        running, storeValid;
    logic [31:0] storeAddr, storeData;
    logic        checkDone;
    int          checkErrors, storesChecked, storesPending;
    int          errorTotal;

    integer      seed;
    logic [31:0] progAddr;
    logic [31:0] imageAddr [$];
    logic [31:0] imageData [$];

    cpuSystem #(
        .ADDR_BITS (ADDR_BITS)
    ) dut0 (
        .clk        (clk),
        .reset_n    (reset_n),
        .halt       (halt),
        .loadEn     (loadEn),
        .loadAddr   (loadAddr),
        .loadData   (loadData),
        .running    (running),
        .storeValid (storeValid),
        .storeAddr  (storeAddr),
        .storeData  (storeData)
    );

    cpuChecker #(
        .ADDR_BITS (ADDR_BITS)
    ) checker0 (
        .clk          (clk),
        .reset_n      (reset_n),
        .halt         (halt),
        .running      (running),
        .loadEn       (loadEn),
        .loadAddr     (loadAddr),
        .loadData     (loadData),
        .storeValid   (storeValid),
        .storeAddr    (storeAddr),
        .storeData    (storeData),
        .done         (checkDone),
        .errorCount   (checkErrors),
        .checkedCount (storesChecked),
        .pendingCount (storesPending)
    );

    bind cpuCore cpuCoreProperties props0 (
        .clk       (clk),
        .reset_n   (reset_n),
        .halt      (halt),
        .state     (state),
        .memStrobe (memStrobe),
        .memWrite  (memWrite)
    );

    function automatic int unsigned pick(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic int unsigned randomAluOp();
        int unsigned v;
        v = pick(15);
        return (v >= 4) ? v + 1 : v;   // Skip the reserved opcode
    endfunction

    // Field order from the top is kind, store, deref, Z, X, Y, op, imm
    function automatic logic [31:0] packInsn(input int kind, input int st, input int dr,
                                             input int z, input int x, input int y,
                                             input int op, input int imm);
        return {kind[1:0], st[0], dr[0], z[3:0], x[3:0], y[3:0], op[3:0], imm[11:0]};
    endfunction

    task automatic putWord(input logic [31:0] addr, input logic [31:0] data);
        imageAddr.push_back(addr);
        imageData.push_back(data);
    endtask

    task automatic emit(input logic [31:0] insn);
        putWord(progAddr, insn);
        progAddr = progAddr + 32'd1;
    endtask

    task automatic buildProgram();
        int unsigned t1, t2, vec1, vec2, cat, kd, z, x, y, op, imm, k, base, off, rz;
        progAddr = cpuPkg::RESET_VECTOR;
        for (int r = 1; r <= 12; r++) begin
            emit(packInsn(cpuPkg::kindXYI, 0, 0, r, 0, 0, cpuPkg::opOr, pick(4096)));
        end
        emit(packInsn(cpuPkg::kindXYI, 0, 0, 13, 0, 0, cpuPkg::opOr, 'h240));  // Data bases
        emit(packInsn(cpuPkg::kindXYI, 0, 0, 14, 0, 0, cpuPkg::opOr, 'h200));
        t1   = 8 + pick(24);
        t2   = 36 + pick(24);
        vec1 = pick(32);
        vec2 = (vec1 + 1 + pick(31)) % 32;
        for (int i = 0; i < BODY_LEN; i++) begin
            cat  = pick(10);
            kd   = pick(3);
            z    = pick(13);
            x    = pick(16);
            y    = pick(16);
            op   = randomAluOp();
            imm  = pick(4096);
            k    = 1 + pick(2);
            base = 13 + pick(2);
            off  = pick(64);
            rz   = 1 + pick(12);
            // A jump must stay in the body and not skip a throw
            if (cat == 9 && (i + k >= BODY_LEN || (t1 > i && t1 <= i + k)
                             || (t2 > i && t2 <= i + k))) begin
                cat = 0;
            end
            if (i == t1 || i == t2) begin
                emit(packInsn(cpuPkg::kindThrow, 0, 0, 0, 0, 0, 0, (i == t1) ? vec1 : vec2));
            end else begin
                case (cat)
                    6: emit(packInsn(cpuPkg::kindXYI, 0, 1, rz, base, 0, cpuPkg::opAdd, off));
                    7: emit(packInsn(cpuPkg::kindXYI, 1, 1, z, base, 0, cpuPkg::opAdd, off));
                    8: emit(packInsn(kd, 1, 0, base, x, y, op, imm));   // Result to [Z]
                    9: emit(packInsn(cpuPkg::kindXYI, 0, 0, 15, 15, 0, cpuPkg::opAdd, k));
                    default: emit(packInsn(kd, 0, 0, z, x, y, op, imm));
                endcase
            end
        end
        for (int r = 1; r <= 14; r++) begin
            emit(packInsn(cpuPkg::kindXYI, 1, 1, r, 0, 0, cpuPkg::opOr, DUMP_BASE + r));
        end
        emit(packInsn(cpuPkg::kindXYI, 0, 0, 15, 15, 0, cpuPkg::opAdd, -1));  // Spin here

        // Handler saves r1 and returns through the trap word
        progAddr = HANDLER_ADDR;
        emit(packInsn(cpuPkg::kindXYI, 1, 1, 1, 0, 0, cpuPkg::opOr, HANDLER_SAVE));
        emit(packInsn(cpuPkg::kindXYI, 0, 1, 15, 0, 0, cpuPkg::opOr, cpuPkg::TRAP_ADDR));
        putWord(cpuPkg::VECTOR_BASE | vec1, HANDLER_ADDR);
        putWord(cpuPkg::VECTOR_BASE | vec2, HANDLER_ADDR);
        for (int a = 'h200; a < 'h280; a++) begin
            putWord(a, $random(seed));
        end
    endtask

    task automatic loadImage();
        for (int i = 0; i < imageAddr.size(); i++) begin
            @(posedge clk);
            loadEn   <= 1'b1;
            loadAddr <= imageAddr[i];
            loadData <= imageData[i];
        end
        @(posedge clk);
        loadEn <= 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        seed     = 32'hef57_67e3;
        reset_n  = 1'b0;
        halt     = 1'b1;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        buildProgram();
        repeat (4) @(posedge clk);
        reset_n <= 1'b1;
        repeat (10) @(posedge clk);   // Idle with halt high
        loadImage();
        @(posedge clk);
        halt <= 1'b0;
        wait (checkDone);
        repeat (40) @(posedge clk);   // Window for stray stores
        errorTotal = checkErrors + dut0.core0.props0.failCount;
        $display("Stores checked: %0d, errors: %0d", storesChecked, errorTotal);
        if (errorTotal == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Watchdog over the execution phase
    initial begin
        wait (reset_n === 1'b1 && halt === 1'b0);
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles: final store not seen, %0d expected stores missing",
                 WATCHDOG_CYCLES, storesPending);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- execUnit.sv
`default_nettype none

module execUnit (
    input  wire                           clk,
    input  wire                           arrangeEn,
    input  wire                           executeEn,
    input  wire cpuPkg::opKind            kind,
    input  wire cpuPkg::aluOp             op,
    input  wire  [cpuPkg::DATA_WIDTH-1:0] valX,
    input  wire  [cpuPkg::DATA_WIDTH-1:0] valY,
    input  wire  [cpuPkg::DATA_WIDTH-1:0] imm,
    output logic [cpuPkg::DATA_WIDTH-1:0] result
);

    logic signed [cpuPkg::DATA_WIDTH-1:0] opA, opB, opC;
    logic signed [cpuPkg::DATA_WIDTH-1:0] opVal;
    logic [4:0]                           shamt;

    assign shamt = opB[4:0];  // Shift amount from the low bits of B

    // Arrange stage
    always_ff @(posedge clk) begin
        if (arrangeEn) begin
            case (kind)
                cpuPkg::kindXYI: begin
                    opA <= valX;
                    opB <= valY;
                    opC <= imm;
                end
                cpuPkg::kindXIY: begin
                    opA <= valX;
                    opB <= imm;
                    opC <= valY;
                end
                cpuPkg::kindIXY: begin
                    opA <= imm;
                    opB <= valX;
                    opC <= valY;
                end
                default: begin
                    opA <= '0;   // Throw uses no operands
                    opB <= '0;
                    opC <= '0;
                end
            endcase
        end
    end

    // Comparisons give all-ones for true
    always_comb begin
        case (op)
            cpuPkg::opOr:   opVal = opA | opB;
            cpuPkg::opAnd:  opVal = opA & opB;
            cpuPkg::opAdd:  opVal = opA + opB;
            cpuPkg::opMul:  opVal = opA * opB;
            cpuPkg::opShl:  opVal = opA << shamt;
            cpuPkg::opLt:   opVal = {cpuPkg::DATA_WIDTH{opA < opB}};
            cpuPkg::opEq:   opVal = {cpuPkg::DATA_WIDTH{opA == opB}};
            cpuPkg::opGe:   opVal = {cpuPkg::DATA_WIDTH{opA >= opB}};
            cpuPkg::opAndn: opVal = opA & ~opB;
            cpuPkg::opXor:  opVal = opA ^ opB;
            cpuPkg::opSub:  opVal = opA - opB;
            cpuPkg::opXnor: opVal = opA ~^ opB;
            cpuPkg::opShr:  opVal = opA >> shamt;    // Logical
            cpuPkg::opNe:   opVal = {cpuPkg::DATA_WIDTH{opA != opB}};
            cpuPkg::opSra:  opVal = opA >>> shamt;   // Keeps the sign of A
            default:        opVal = '0;              // Reserved opcode
        endcase
    end

    // Execute stage, operation plus addend
    always_ff @(posedge clk) begin
        if (executeEn) begin
            result <= opVal + opC;
        end
    end

endmodule

`default_nettype wire

//--- insnDecode.sv
`default_nettype none

module insnDecode (
    input  wire  [cpuPkg::DATA_WIDTH-1:0] insn,
    output logic [3:0]                    idxZ,
    output logic [3:0]                    idxX,
    output logic [3:0]                    idxY,
    output logic [cpuPkg::DATA_WIDTH-1:0] imm,
    output cpuPkg::aluOp                  op,
    output cpuPkg::opKind                 kind,
    output logic                          storing,
    output logic                          derefRhs,
    output logic                          throwing,
    output logic                          jumping,
    output logic [4:0]                    vector
);

    // Fields from the top: kind, store, deref, Z, X, Y, op, imm
    assign kind     = cpuPkg::opKind'(insn[31:30]);
    assign storing  = insn[29];
    assign derefRhs = insn[28];
    assign idxZ     = insn[27:24];
    assign idxX     = insn[23:20];
    assign idxY     = insn[19:16];
    assign op       = cpuPkg::aluOp'(insn[15:12]);
    assign imm      = {{(cpuPkg::DATA_WIDTH-12){insn[11]}}, insn[11:0]};

    assign vector   = insn[4:0];    // Throw vector overlaps the immediate
    assign throwing = (kind == cpuPkg::kindThrow);
    assign jumping  = (idxZ == 4'd15) && !storing;

endmodule

`default_nettype wire

//--- regFile.sv
`default_nettype none

module regFile (
    input  wire                           clk,
    input  wire                           writeEn,
    input  wire  [3:0]                    idxZ,
    input  wire  [3:0]                    idxX,
    input  wire  [3:0]                    idxY,
    input  wire  [cpuPkg::DATA_WIDTH-1:0] nextZ,
    input  wire  [cpuPkg::DATA_WIDTH-1:0] nextP,
    output logic [cpuPkg::DATA_WIDTH-1:0] valZ,
    output logic [cpuPkg::DATA_WIDTH-1:0] valX,
    output logic [cpuPkg::DATA_WIDTH-1:0] valY
);

    logic [cpuPkg::DATA_WIDTH-1:0] regs [1:14];

    // Index 15 is P, index 0 is hardwired zero
    assign valZ = (idxZ == 4'd15) ? nextP : (idxZ == 4'd0) ? '0 : regs[idxZ];
    assign valX = (idxX == 4'd15) ? nextP : (idxX == 4'd0) ? '0 : regs[idxX];
    assign valY = (idxY == 4'd15) ? nextP : (idxY == 4'd0) ? '0 : regs[idxY];

    // P is written by the core sequencer, not here
    always_ff @(posedge clk) begin
        if (writeEn && idxZ != 4'd0 && idxZ != 4'd15) begin
            regs[idxZ] <= nextZ;
        end
    end

endmodule

`default_nettype wire

//--- sim.f
cpuPkg.sv
regFile.sv
insnDecode.sv
execUnit.sv
cpuCore.sv
unifiedMem.sv
cpuSystem.sv
cpuCore_properties.sv
cpuChecker.sv
cpuTb.sv

//--- unifiedMem.sv
`default_nettype none

module unifiedMem #(
    parameter int ADDR_BITS = 10
) (
    input  wire                           clk,
    input  wire  [cpuPkg::DATA_WIDTH-1:0] iAddr,
    output logic [cpuPkg::DATA_WIDTH-1:0] iData,
    input  wire  [cpuPkg::DATA_WIDTH-1:0] dAddr,
    input  wire  [cpuPkg::DATA_WIDTH-1:0] dWrData,
    output logic [cpuPkg::DATA_WIDTH-1:0] dRdData,
    input  wire                           dStrobe,
    input  wire                           dWrite,
    input  wire                           loadEn,
    input  wire  [cpuPkg::DATA_WIDTH-1:0] loadAddr,
    input  wire  [cpuPkg::DATA_WIDTH-1:0] loadData
);

    logic [cpuPkg::DATA_WIDTH-1:0] mem [0:(2**ADDR_BITS)-1];

    logic [ADDR_BITS-1:0] iIdx, dIdx, loadIdx;

    // Word addresses, upper bits dropped
    assign iIdx    = iAddr[ADDR_BITS-1:0];
    assign dIdx    = dAddr[ADDR_BITS-1:0];
    assign loadIdx = loadAddr[ADDR_BITS-1:0];

    // Asynchronous reads on both ports
    assign iData   = mem[iIdx];
    assign dRdData = mem[dIdx];

    always_ff @(posedge clk) begin
        if (loadEn) begin
            mem[loadIdx] <= loadData;   // External load wins
        end else if (dStrobe && dWrite) begin
            mem[dIdx] <= dWrData;
        end
    end

endmodule

`default_nettype wire
